// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = nco_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+source
source/nco_pkg.sv
source/nco_cfg_regs.sv
source/nco_phase_acc.sv
source/nco_trig_table.sv
source/nco_top.sv
tb/nco_chk.sv
tb/nco_tb.sv

// File: source/nco_cfg_regs.sv
// NCO register block that decodes host write strobes into the live oscillator settings.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_cfg_regs
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cfg_wr,
	input  nco_pkg::nco_reg_addr_e    cfg_addr,
	input  logic [`NCO_ACC_WIDTH-1:0] cfg_wdata,
	output nco_pkg::nco_cfg_t         cfg,
	output logic                      phase_clear
);

	import nco_pkg::*;

	// Control word layout.
	localparam int ctrl_enable_bit  = 0;
	localparam int ctrl_neg_sin_bit = 1;
	localparam int ctrl_neg_cos_bit = 2;
	localparam int ctrl_clear_bit   = 3;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg         <= '0;
			phase_clear <= 1'b0;
		end
		else
		begin
			// Clear is a pulse and is never held.
			phase_clear <= 1'b0;
			if (cfg_wr)
			begin
				case (cfg_addr)
					REG_PHASE_INC:
					begin
						cfg.phase_inc <= cfg_wdata;
					end
					REG_PHASE_OFS:
					begin
						cfg.phase_ofs <= cfg_wdata;
					end
					REG_CTRL:
					begin
						cfg.enable  <= cfg_wdata[ctrl_enable_bit];
						cfg.neg_sin <= cfg_wdata[ctrl_neg_sin_bit];
						cfg.neg_cos <= cfg_wdata[ctrl_neg_cos_bit];
						phase_clear <= cfg_wdata[ctrl_clear_bit];
					end
					default:
					begin
						// Unmapped opcodes drop the write.
					end
				endcase
			end
		end
	end

endmodule

// File: source/nco_defines.svh
// Width macros shared by the NCO RTL and its testbench and included by every file that sizes a port.
`ifndef NCO_DEFINES_SVH
`define NCO_DEFINES_SVH

// Phase accumulator width.
// The increment and the offset registers use the same width.
`define NCO_ACC_WIDTH 24

// Quantized phase width.
// This sets the table depth to 2**NCO_THETA_WIDTH entries.
`define NCO_THETA_WIDTH 10

// Width of each signed output sample.
`define NCO_OUT_WIDTH 16

`endif

// File: source/nco_phase_acc.sv
// NCO phase accumulator that advances on each enabled tick and emits the quantized table address.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_phase_acc
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        tick,
	input  nco_pkg::nco_cfg_t           cfg,
	input  logic                        phase_clear,
	output logic [`NCO_THETA_WIDTH-1:0] theta,
	output logic                        theta_valid
);

	logic [`NCO_ACC_WIDTH-1:0] acc;
	logic [`NCO_ACC_WIDTH-1:0] phase;
	logic                      accept;

	// Ticks are ignored while the oscillator is disabled.
	assign accept = tick && cfg.enable;

	// Offset is applied to the value before this tick's increment.
	assign phase = acc + cfg.phase_ofs;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc         <= '0;
			theta       <= '0;
			theta_valid <= 1'b0;
		end
		else
		begin
			theta_valid <= accept;
			if (accept)
			begin
				theta <= phase[`NCO_ACC_WIDTH-1 -: `NCO_THETA_WIDTH];
			end

			// Clear wins over the increment and the sum wraps on its own.
			if (phase_clear)
			begin
				acc <= '0;
			end
			else if (accept)
			begin
				acc <= acc + cfg.phase_inc;
			end
		end
	end

endmodule

// File: source/nco_pkg.sv
// Shared NCO types for the register opcodes, the live settings and the output samples.
`include "nco_defines.svh"

package nco_pkg;

	// Write opcodes decoded by the register block.
	typedef enum logic [1:0]
	{
		REG_PHASE_INC = 2'd0,
		REG_PHASE_OFS = 2'd1,
		REG_CTRL      = 2'd2
	} nco_reg_addr_e;

	// Settings as seen by the accumulator and the table.
	typedef struct packed
	{
		logic [`NCO_ACC_WIDTH-1:0] phase_inc;
		logic [`NCO_ACC_WIDTH-1:0] phase_ofs;
		logic                      enable;
		logic                      neg_sin;
		logic                      neg_cos;
	} nco_cfg_t;

	// One quadrature output sample.
	typedef struct packed
	{
		logic signed [`NCO_OUT_WIDTH-1:0] sin;
		logic signed [`NCO_OUT_WIDTH-1:0] cos;
	} nco_sample_t;

endpackage

// File: source/nco_top.sv
// NCO top level joining the register block, the phase accumulator and the lookup table.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_top
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cfg_wr,
	input  nco_pkg::nco_reg_addr_e    cfg_addr,
	input  logic [`NCO_ACC_WIDTH-1:0] cfg_wdata,
	input  logic                      tick,
	output nco_pkg::nco_sample_t      sample,
	output logic                      out_valid
);

	import nco_pkg::*;

	nco_cfg_t                    cfg;
	logic                        phase_clear;
	logic [`NCO_THETA_WIDTH-1:0] theta;
	logic                        theta_valid;

	nco_cfg_regs u_cfg_regs
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg         (cfg),
		.phase_clear (phase_clear)
	);

	nco_phase_acc u_phase_acc
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.tick        (tick),
		.cfg         (cfg),
		.phase_clear (phase_clear),
		.theta       (theta),
		.theta_valid (theta_valid)
	);

	// Negate flags ride along with the lookup.
	nco_trig_table u_trig_table
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.theta       (theta),
		.theta_valid (theta_valid),
		.neg_sin     (cfg.neg_sin),
		.neg_cos     (cfg.neg_cos),
		.sample      (sample),
		.out_valid   (out_valid)
	);

endmodule

// File: source/nco_trig_table.sv
// NCO quadrature lookup table that is filled at elaboration and read through a registered output.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_trig_table
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`NCO_THETA_WIDTH-1:0] theta,
	input  logic                        theta_valid,
	input  logic                        neg_sin,
	input  logic                        neg_cos,
	output nco_pkg::nco_sample_t        sample,
	output logic                        out_valid
);

	import nco_pkg::*;

	localparam int  table_size   = 1 << `NCO_THETA_WIDTH;
	localparam int  full_scale   = 1 << (`NCO_OUT_WIDTH - 1);
	localparam int  series_terms = 24;
	localparam real pi           = 3.14159265358979323846;
	localparam real delta_angle  = 2.0 * pi / table_size;

	logic signed [`NCO_OUT_WIDTH-1:0] sin_array [0:table_size-1];
	logic signed [`NCO_OUT_WIDTH-1:0] cos_array [0:table_size-1];

	nco_sample_t lut_val;

	// Power series about zero for arguments within half a turn.
	function automatic real taylor_sin(input real x);
		real term;
		real sum;
		term = x;
		sum  = x;
		for (int n = 3; n < 2 * series_terms; n += 2)
		begin
			term = -term * x * x / ((n - 1) * n);
			sum  = sum + term;
		end
		return sum;
	endfunction

	function automatic real taylor_cos(input real x);
		real term;
		real sum;
		term = 1.0;
		sum  = 1.0;
		for (int n = 2; n < 2 * series_terms; n += 2)
		begin
			term = -term * x * x / ((n - 1) * n);
			sum  = sum + term;
		end
		return sum;
	endfunction

	// Truncate toward zero and hold one step inside full scale.
	function automatic logic signed [`NCO_OUT_WIDTH-1:0] to_sample(input real unit);
		int value;
		value = $rtoi(unit * full_scale);
		if (value >= full_scale)
		begin
			value = full_scale - 1;
		end
		else if (value <= -full_scale)
		begin
			value = -(full_scale - 1);
		end
		return value[`NCO_OUT_WIDTH-1:0];
	endfunction

	initial
	begin
		real angle;
		for (int i = 0; i < table_size; i++)
		begin
			angle = delta_angle * i;
			if (angle > pi)
			begin
				angle = angle - 2.0 * pi;
			end
			sin_array[i] = to_sample(taylor_sin(angle));
			cos_array[i] = to_sample(taylor_cos(angle));
		end
	end

	always_comb
	begin
		lut_val.sin = sin_array[theta];
		lut_val.cos = cos_array[theta];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sample    <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= theta_valid;
			if (theta_valid)
			begin
				sample.sin <= neg_sin ? -lut_val.sin : lut_val.sin;
				sample.cos <= neg_cos ? -lut_val.cos : lut_val.cos;
			end
		end
	end

endmodule

// File: tb/nco_chk.sv
// Concurrent checks on NCO pipeline timing and output range that are bound into the top level.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_chk
(
	input logic                 clk,
	input logic                 rst_n,
	input logic                 tick,
	input logic                 enable,
	input logic                 neg_sin,
	input logic                 neg_cos,
	input nco_pkg::nco_sample_t sample,
	input logic                 out_valid
);

	localparam logic signed [`NCO_OUT_WIDTH-1:0] most_negative =
		{1'b1, {(`NCO_OUT_WIDTH - 1){1'b0}}};

	// Count of assertion failures, read by the testbench.
	int fail_count = 0;

	// Fixed two-cycle latency from an accepted tick.
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(tick && enable) |-> ##2 out_valid)
		else
		begin
			fail_count++;
			$error("out_valid missing two cycles after an accepted tick");
		end

	a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(tick && enable, 2))
		else
		begin
			fail_count++;
			$error("out_valid without an accepted tick two cycles earlier");
		end

	a_reset_low: assert property (@(posedge clk)
		!rst_n |=> !out_valid)
		else
		begin
			fail_count++;
			$error("out_valid high during reset");
		end

	// Flags were sampled one cycle before the output register loaded.
	a_sin_range: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !$past(neg_sin)) |-> (sample.sin != most_negative))
		else
		begin
			fail_count++;
			$error("sin sample reached negative full scale");
		end

	a_cos_range: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !$past(neg_cos)) |-> (sample.cos != most_negative))
		else
		begin
			fail_count++;
			$error("cos sample reached negative full scale");
		end

endmodule

bind nco_top nco_chk u_chk
(
	.clk       (clk),
	.rst_n     (rst_n),
	.tick      (tick),
	.enable    (cfg.enable),
	.neg_sin   (cfg.neg_sin),
	.neg_cos   (cfg.neg_cos),
	.sample    (sample),
	.out_valid (out_valid)
);

// File: tb/nco_tb.sv
// Directed testbench for the NCO top level that checks every sample against a floating-point model.
`timescale 1ns/10ps

`include "nco_defines.svh"

module nco_tb;

	import nco_pkg::*;

	localparam int acc_w      = `NCO_ACC_WIDTH;
	localparam int theta_w    = `NCO_THETA_WIDTH;
	localparam int clk_period = 8;
	localparam int wait_limit = 64;
	localparam real ref_pi    = 3.14159265358979323846;

	// Rough test lengths in cycles for the six tests in run order.
	localparam int test_cycles     = 30 + 100 + 150 + 150 + 90 + 50;
	localparam int watchdog_cycles = 2 * test_cycles;

	logic              clk;
	logic              rst_n;
	logic              cfg_wr;
	nco_reg_addr_e     cfg_addr;
	logic [acc_w-1:0]  cfg_wdata;
	logic              tick;
	nco_sample_t       sample;
	logic              out_valid;

	int exp_sin [$];
	int exp_cos [$];
	int got_sin [$];
	int got_cos [$];
	int got_cyc [$];

	int cyc = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;

	logic [acc_w-1:0] phase_inc;
	logic [acc_w-1:0] phase_ofs;
	bit               neg_sin_flag;
	bit               neg_cos_flag;

	nco_top dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.tick      (tick),
		.sample    (sample),
		.out_valid (out_valid)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
	end

	// Outputs are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge clk)
	begin
		if (rst_n === 1'b1 && out_valid === 1'b1)
		begin
			got_sin.push_back(int'(sample.sin));
			got_cos.push_back(int'(sample.cos));
			got_cyc.push_back(cyc);
		end
	end

	// Expected table entry truncated toward zero and held inside full scale.
	function automatic int ref_value(input int t, input bit use_cos);
		real angle;
		real unit;
		int  limit;
		int  value;
		limit = (1 << (`NCO_OUT_WIDTH - 1)) - 1;
		angle = 2.0 * ref_pi * t / real'(1 << theta_w);
		if (use_cos)
		begin
			unit = $cos(angle);
		end
		else
		begin
			unit = $sin(angle);
		end
		value = $rtoi(unit * real'(limit + 1));
		if (value > limit)
		begin
			value = limit;
		end
		else if (value < -limit)
		begin
			value = -limit;
		end
		return value;
	endfunction

	function automatic bit within_one(input int a, input int b);
		return (a - b <= 1) && (b - a <= 1);
	endfunction

	// Scoreboard errors plus failures of the bound assertions.
	function automatic int all_errors();
		return error_count + dut.u_chk.fail_count;
	endfunction

	task automatic write_reg(input nco_reg_addr_e addr, input logic [acc_w-1:0] data);
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_wr = 1'b0;
		// One more cycle lets a clear pulse reach the accumulator.
		@(negedge clk);
	endtask

	task automatic write_ctrl(input bit enable, input bit ns, input bit nc, input bit clear);
		logic [acc_w-1:0] word;
		word         = {20'd0, clear, nc, ns, enable};
		neg_sin_flag = ns;
		neg_cos_flag = nc;
		write_reg(REG_CTRL, word);
	endtask

	task automatic issue_ticks(input int count, input int gap);
		for (int i = 0; i < count; i++)
		begin
			tick = 1'b1;
			@(negedge clk);
			tick = 1'b0;
			repeat (gap) @(negedge clk);
		end
	endtask

	// Sample k after a clear sits at phase k*inc + ofs.
	task automatic expect_sample(input int k);
		logic [acc_w-1:0] phase;
		int               idx;
		int               s;
		int               c;
		phase = phase_ofs + 24'(k) * phase_inc;
		idx   = int'(phase[acc_w-1 -: theta_w]);
		s     = ref_value(idx, 1'b0);
		c     = ref_value(idx, 1'b1);
		exp_sin.push_back(neg_sin_flag ? -s : s);
		exp_cos.push_back(neg_cos_flag ? -c : c);
	endtask

	task automatic wait_outputs(input string name);
		int waited;
		waited = 0;
		while (got_sin.size() < exp_sin.size() && waited < wait_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (got_sin.size() < exp_sin.size())
		begin
			$display("Test %s: only %0d of %0d samples arrived within %0d cycles",
				name, got_sin.size(), exp_sin.size(), wait_limit);
			error_count++;
		end
		// Extra samples would show up here.
		repeat (4) @(negedge clk);
	endtask

	task automatic check_outputs(input string name);
		int n;
		if (got_sin.size() != exp_sin.size())
		begin
			$display("error at %0d ns: test %s produced %0d samples, expected %0d",
				$time, name, got_sin.size(), exp_sin.size());
			error_count++;
		end
		n = (got_sin.size() < exp_sin.size()) ? got_sin.size() : exp_sin.size();
		for (int i = 0; i < n; i++)
		begin
			if (!within_one(got_sin[i], exp_sin[i]))
			begin
				$display("error at %0d ns: test %s sample %0d sin is %0d, expected %0d",
					$time, name, i, got_sin[i], exp_sin[i]);
				error_count++;
			end
			if (!within_one(got_cos[i], exp_cos[i]))
			begin
				$display("error at %0d ns: test %s sample %0d cos is %0d, expected %0d",
					$time, name, i, got_cos[i], exp_cos[i]);
				error_count++;
			end
		end
		exp_sin.delete();
		exp_cos.delete();
		got_sin.delete();
		got_cos.delete();
		got_cyc.delete();
	endtask

	task automatic begin_test();
		tests_run++;
		test_start_errors = all_errors();
	endtask

	task automatic end_test(input string name);
		if (all_errors() > test_start_errors)
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, all_errors() - test_start_errors);
		end
		else
		begin
			$display("test %s passed", name);
		end
	endtask

	task automatic test_reset();
		begin_test();
		if (out_valid !== 1'b0)
		begin
			$display("error at %0d ns: test reset out_valid is %b after reset", $time, out_valid);
			error_count++;
		end
		// Enable is still low, so none of these ticks may produce a sample.
		issue_ticks(4, 1);
		wait_outputs("reset");
		check_outputs("reset");
		end_test("reset");
	endtask

	task automatic test_static_phase();
		logic [acc_w-1:0] offsets [6];
		begin_test();
		offsets = '{24'h000000, 24'h400000, 24'h800000, 24'hC00000, 24'h123456, 24'h0};
		offsets[5] = 24'($urandom);
		phase_inc  = '0;
		write_reg(REG_PHASE_INC, phase_inc);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 6; i++)
		begin
			phase_ofs = offsets[i];
			write_reg(REG_PHASE_OFS, phase_ofs);
			expect_sample(0);
			issue_ticks(1, 0);
			wait_outputs("static_phase");
			if (got_sin.size() > 0)
			begin
				if (phase_ofs == 24'h000000 && got_cos[0] != 32767)
				begin
					$display("error at %0d ns: test static_phase cos at 0 deg is %0d, expected 32767",
						$time, got_cos[0]);
					error_count++;
				end
				if (phase_ofs == 24'h400000 && got_sin[0] != 32767)
				begin
					$display("error at %0d ns: test static_phase sin at 90 deg is %0d, expected 32767",
						$time, got_sin[0]);
					error_count++;
				end
				if (phase_ofs == 24'h800000 && got_cos[0] != -32767)
				begin
					$display("error at %0d ns: test static_phase cos at 180 deg is %0d, expected -32767",
						$time, got_cos[0]);
					error_count++;
				end
			end
			check_outputs("static_phase");
		end
		end_test("static_phase");
	endtask

	task automatic test_accumulation();
		begin_test();
		phase_inc = 24'($urandom);
		phase_ofs = 24'($urandom);
		write_reg(REG_PHASE_INC, phase_inc);
		write_reg(REG_PHASE_OFS, phase_ofs);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (int k = 0; k < 32; k++)
		begin
			expect_sample(k);
		end
		issue_ticks(32, 3);
		wait_outputs("accumulation");
		check_outputs("accumulation");
		end_test("accumulation");
	endtask

	task automatic test_negation();
		begin_test();
		phase_inc = 24'($urandom);
		phase_ofs = 24'($urandom);
		write_reg(REG_PHASE_INC, phase_inc);
		write_reg(REG_PHASE_OFS, phase_ofs);
		for (int combo = 0; combo < 4; combo++)
		begin
			write_ctrl(1'b1, combo[0], combo[1], 1'b1);
			for (int k = 0; k < 8; k++)
			begin
				expect_sample(k);
			end
			issue_ticks(8, 2);
			wait_outputs("negation");
			check_outputs("negation");
		end
		end_test("negation");
	endtask

	task automatic test_clear_enable();
		begin_test();
		phase_inc = 24'($urandom);
		phase_ofs = 24'($urandom);
		write_reg(REG_PHASE_INC, phase_inc);
		write_reg(REG_PHASE_OFS, phase_ofs);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (int k = 0; k < 6; k++)
		begin
			expect_sample(k);
		end
		issue_ticks(6, 2);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (int k = 0; k < 4; k++)
		begin
			expect_sample(k);
		end
		issue_ticks(4, 2);
		// Disabled ticks neither advance the phase nor produce samples.
		write_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
		issue_ticks(4, 2);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
		for (int k = 4; k < 8; k++)
		begin
			expect_sample(k);
		end
		issue_ticks(4, 2);
		wait_outputs("clear_enable");
		check_outputs("clear_enable");
		end_test("clear_enable");
	endtask

	task automatic test_pipeline();
		int first_cyc;
		begin_test();
		phase_inc = 24'($urandom);
		phase_ofs = 24'($urandom);
		write_reg(REG_PHASE_INC, phase_inc);
		write_reg(REG_PHASE_OFS, phase_ofs);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (int k = 0; k < 20; k++)
		begin
			expect_sample(k);
		end
		first_cyc = cyc;
		issue_ticks(20, 0);
		wait_outputs("pipeline");
		for (int i = 0; i < got_cyc.size(); i++)
		begin
			if (got_cyc[i] != first_cyc + 2 + i)
			begin
				$display("error at %0d ns: test pipeline sample %0d came in cycle %0d, expected %0d",
					$time, i, got_cyc[i], first_cyc + 2 + i);
				error_count++;
			end
		end
		check_outputs("pipeline");
		end_test("pipeline");
	endtask

	initial
	begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		void'($urandom(3));
		clk          = 1'b0;
		rst_n        = 1'b0;
		cfg_wr       = 1'b0;
		cfg_addr     = REG_PHASE_INC;
		cfg_wdata    = '0;
		tick         = 1'b0;
		phase_inc    = '0;
		phase_ofs    = '0;
		neg_sin_flag = 1'b0;
		neg_cos_flag = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_reset();
		test_static_phase();
		test_accumulation();
		test_negation();
		test_clear_enable();
		test_pipeline();

		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, dut.u_chk.fail_count);
		if (all_errors() == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
